// ==== hdl/ppu_pkg.sv ====
/*
 * PPU register core shared definitions
 * Register slot encoding, bus and address types, palette and frame constants
 */
`default_nettype none

package ppu_pkg;

	// CPU register slots, in ain order
	typedef enum logic [2:0] {
		reg_ctrl     = 3'd0,
		reg_mask     = 3'd1,
		reg_status   = 3'd2,
		reg_oam_addr = 3'd3,
		reg_oam_data = 3'd4,
		reg_scroll   = 3'd5,
		reg_addr     = 3'd6,
		reg_data     = 3'd7
	} reg_sel_e;

	typedef logic [7:0]  cpu_byte_t;  // One byte on the CPU bus
	typedef logic [13:0] vram_addr_t; // External VRAM address
	typedef logic [14:0] vram_ptr_t;  // Address register, bit 14 catches the carry
	typedef logic [4:0]  pal_index_t; // Palette RAM index
	typedef logic [5:0]  color_t;     // Palette entry

	// Address bits 13:8 of palette space
	localparam logic [5:0] PAL_PAGE = 6'h3F;

	// Step taken with control bit 2 set, one full row of tiles
	localparam vram_ptr_t INC_ACROSS = 15'd32;

	// Scanline counter value of the pre-render line
	localparam logic [8:0] PRE_RENDER_LINE = 9'd511;

endpackage

`default_nettype wire

// ==== hdl/ppu_bus_if.sv ====
/*
 * PPU register bus
 * One decoded CPU register access, valid for a single cycle
 */
`timescale 1ns/1ps
`default_nettype none

interface ppu_bus_if;
	import ppu_pkg::*;

	logic      wr;    // Write strobe
	logic      rd;    // Read strobe
	reg_sel_e  sel;   // Register slot
	cpu_byte_t wdata; // Write data

	// Decoder side
	modport host (
		output wr, rd, sel, wdata
	);

	// Register units
	modport unit (
		input wr, rd, sel, wdata
	);

endinterface

`default_nettype wire

// ==== hdl/frame_timer.sv ====
/*
 * Frame timer
 * Cycle and scanline counters with the wrap through the pre-render line,
 * plus the single-cycle vblank entry and exit events
 */
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
	parameter int CYCLES_PER_LINE = 341,
	parameter int VBLANK_LINE     = 241,
	parameter int LAST_LINE       = 260
) (
	input  wire logic       clk,
	input  wire logic       reset,
	output logic      [8:0] cycle,
	output logic      [8:0] scanline,
	output logic            vblank_enter,
	output logic            vblank_exit
);
	import ppu_pkg::*;

	logic line_end; // Last cycle of the current line
	logic last_line; // Final vblank line, pre-render comes next

	assign line_end  = (cycle == 9'(CYCLES_PER_LINE - 1));
	assign last_line = (scanline == 9'(LAST_LINE));

	// Cycle counter runs every clock
	always_ff @(posedge clk) begin
		if (reset) begin
			cycle <= '0;
		end else begin
			cycle <= line_end ? 9'd0 : cycle + 9'd1;
		end
	end

	// Scanline steps at end of line
	always_ff @(posedge clk) begin
		if (reset) begin
			scanline <= '0;
		end else if (line_end) begin
			if (last_line)
				scanline <= PRE_RENDER_LINE; // Line -1
			else if (scanline == PRE_RENDER_LINE)
				scanline <= 9'd0; // Back to top of frame
			else
				scanline <= scanline + 9'd1;
		end
	end

	// Events land on cycle 0 so the flag is visible from cycle 1
	assign vblank_enter = (cycle == 9'd0) && (scanline == 9'(VBLANK_LINE));
	assign vblank_exit  = (cycle == 9'd0) && (scanline == PRE_RENDER_LINE);

endmodule

`default_nettype wire

// ==== hdl/ppu_ctrl_regs.sv ====
/*
 * PPU control and status registers
 * Control bits, vblank flag with NMI, shared write toggle
 * and the CPU bus latch that doubles as registered read data
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_ctrl_regs #(
	parameter int LAST_LINE = 260
) (
	input  wire logic                clk,
	input  wire logic                reset,
	ppu_bus_if.unit                  bus,
	input  wire logic                vblank_enter,
	input  wire logic                vblank_exit,
	input  wire ppu_pkg::cpu_byte_t  rd_buffer,
	input  wire logic                is_pal,
	input  wire ppu_pkg::color_t     pal_color,
	output ppu_pkg::vram_ptr_t       addr_step,
	output logic                     addr_toggle,
	output logic                     nmi,
	output ppu_pkg::cpu_byte_t       dout
);
	import ppu_pkg::*;

	// Vblank must end on the pre-render line, after the last counted line
	if (LAST_LINE >= int'(PRE_RENDER_LINE)) begin : g_line_order
		$error("LAST_LINE must lie below the pre-render line");
	end

	logic inc_across;  // Control bit 2
	logic nmi_enable;  // Control bit 7
	logic vblank_flag; // Status bit 7
	logic toggle;      // First/second write select for scroll and addr
	logic status_rd;
	logic toggle_wr;

	assign status_rd = bus.rd && (bus.sel == reg_status);
	assign toggle_wr = bus.wr && (bus.sel == reg_scroll || bus.sel == reg_addr);

	// Control register, only the two bits this core still uses
	always_ff @(posedge clk) begin
		if (reset) begin
			inc_across <= 1'b0;
			nmi_enable <= 1'b0;
		end else if (bus.wr && bus.sel == reg_ctrl) begin
			inc_across <= bus.wdata[2];
			nmi_enable <= bus.wdata[7];
		end
	end

	// Vblank flag, a status read wins over a coincident entry
	always_ff @(posedge clk) begin
		if (reset) begin
			vblank_flag <= 1'b0;
		end else if (status_rd) begin
			vblank_flag <= 1'b0;
		end else if (vblank_enter) begin
			vblank_flag <= 1'b1;
		end else if (vblank_exit) begin
			vblank_flag <= 1'b0; // Pre-render line clears it
		end
	end

	// Shared toggle for scroll and addr writes
	always_ff @(posedge clk) begin
		if (reset)
			toggle <= 1'b0;
		else if (status_rd)
			toggle <= 1'b0;
		else if (toggle_wr)
			toggle <= ~toggle;
	end

	// Bus latch, every write lands here, reads pick their source
	always_ff @(posedge clk) begin
		if (reset) begin
			dout <= '0;
		end else if (bus.wr) begin
			dout <= bus.wdata;
		end else if (bus.rd) begin
			case (bus.sel)
				reg_status: dout <= {vblank_flag, 2'b00, dout[4:0]}; // Sprite bits read 0
				reg_data:   dout <= is_pal ? {dout[7:6], pal_color} : rd_buffer;
				default:    dout <= dout; // Open bus
			endcase
		end
	end

	assign addr_step   = inc_across ? INC_ACROSS : 15'd1;
	assign addr_toggle = toggle;
	assign nmi         = vblank_flag & nmi_enable;

endmodule

`default_nettype wire

// ==== hdl/vram_addr_unit.sv ====
/*
 * VRAM address unit
 * Two-write address load, step after each data access,
 * palette decode, external strobes and the buffered read path
 */
`timescale 1ns/1ps
`default_nettype none

module vram_addr_unit (
	input  wire logic                clk,
	input  wire logic                reset,
	ppu_bus_if.unit                  bus,
	input  wire logic                addr_toggle,
	input  wire ppu_pkg::vram_ptr_t  addr_step,
	input  wire ppu_pkg::cpu_byte_t  vram_din,
	output ppu_pkg::vram_addr_t      vram_a,
	output logic                     vram_r,
	output logic                     vram_w,
	output logic                     is_pal,
	output ppu_pkg::pal_index_t      pal_addr,
	output ppu_pkg::cpu_byte_t       rd_buffer
);
	import ppu_pkg::*;

	logic      [6:0] addr_hi;    // Bits 14:8 waiting for the second write
	vram_ptr_t       vram_ptr;   // Current address register
	logic            rd_pending; // External read answers this cycle
	logic            addr_wr;
	logic            data_acc;

	assign addr_wr  = bus.wr && (bus.sel == reg_addr);
	assign data_acc = (bus.rd || bus.wr) && (bus.sel == reg_data);

	// First write holds the high byte, bit 14 forced low
	always_ff @(posedge clk) begin
		if (addr_wr && !addr_toggle)
			addr_hi <= {1'b0, bus.wdata[5:0]};
	end

	// Address register
	always_ff @(posedge clk) begin
		if (reset) begin
			vram_ptr <= '0;
		end else if (addr_wr && addr_toggle) begin
			vram_ptr <= {addr_hi, bus.wdata}; // Second write completes it
		end else if (data_acc) begin
			vram_ptr <= vram_ptr + addr_step;
		end
	end

	assign is_pal   = (vram_ptr[13:8] == PAL_PAGE);
	assign pal_addr = vram_ptr[4:0];
	assign vram_a   = vram_ptr[13:0];

	// Palette accesses stay inside the core
	assign vram_r = bus.rd && (bus.sel == reg_data) && !is_pal;
	assign vram_w = bus.wr && (bus.sel == reg_data) && !is_pal;

	// VRAM data shows up one cycle after the strobe
	always_ff @(posedge clk) begin
		if (reset)
			rd_pending <= 1'b0;
		else
			rd_pending <= vram_r;
	end

	// Read buffer, returned by the next data read
	always_ff @(posedge clk) begin
		if (reset)
			rd_buffer <= '0;
		else if (rd_pending)
			rd_buffer <= vram_din;
	end

endmodule

`default_nettype wire

// ==== hdl/palette_ram.sv ====
/*
 * Palette RAM
 * 32 six-bit colour entries, sprite backdrop slots fold onto the
 * background ones
 */
`timescale 1ns/1ps
`default_nettype none

module palette_ram (
	input  wire logic                clk,
	input  wire logic                reset,
	ppu_bus_if.unit                  bus,
	input  wire ppu_pkg::pal_index_t pal_addr,
	input  wire logic                is_pal,
	output ppu_pkg::color_t          pal_color
);
	import ppu_pkg::*;

	color_t     entries [32];
	pal_index_t index; // Index after backdrop folding

	// 0x10/0x14/0x18/0x1C alias 0x00/0x04/0x08/0x0C
	assign index = (pal_addr[1:0] == 2'b00) ? {1'b0, pal_addr[3:0]} : pal_addr;

	assign pal_color = entries[index]; // Async read

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				entries[i] <= '0;
		end else if (bus.wr && bus.sel == reg_data && is_pal) begin
			entries[index] <= bus.wdata[5:0]; // Upper two bits dropped
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ppu_top.sv ====
/*
 * PPU register and timing core, top level
 * CPU register bus, frame timing, VRAM address path and palette
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_top #(
	parameter int CYCLES_PER_LINE = 341, // 341 for NTSC and PAL
	parameter int VBLANK_LINE     = 241,
	parameter int LAST_LINE       = 260  // 310 for PAL
) (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic          [2:0] ain,      // Register select from CPU
	input  wire ppu_pkg::cpu_byte_t  din,
	input  wire logic                read,
	input  wire logic                write,
	input  wire ppu_pkg::cpu_byte_t  vram_din,
	output ppu_pkg::cpu_byte_t       dout,
	output logic                     nmi,
	output logic                     vram_r,
	output logic                     vram_w,
	output ppu_pkg::vram_addr_t      vram_a,
	output ppu_pkg::cpu_byte_t       vram_dout,
	output logic               [8:0] scanline,
	output logic               [8:0] cycle
);
	import ppu_pkg::*;

	ppu_bus_if bus ();

	logic       vblank_enter;
	logic       vblank_exit;
	vram_ptr_t  addr_step;
	logic       addr_toggle;
	cpu_byte_t  rd_buffer;
	logic       is_pal;
	pal_index_t pal_addr;
	color_t     pal_color;

	// Plain CPU pins onto the register bus
	assign bus.wr    = write;
	assign bus.rd    = read;
	assign bus.sel   = reg_sel_e'(ain);
	assign bus.wdata = din;

	assign vram_dout = din; // Writes go out unchanged

	frame_timer #(
		.CYCLES_PER_LINE (CYCLES_PER_LINE),
		.VBLANK_LINE     (VBLANK_LINE),
		.LAST_LINE       (LAST_LINE)
	) u_frame_timer (
		.clk          (clk),
		.reset        (reset),
		.cycle        (cycle),
		.scanline     (scanline),
		.vblank_enter (vblank_enter),
		.vblank_exit  (vblank_exit)
	);

	ppu_ctrl_regs #(
		.LAST_LINE (LAST_LINE)
	) u_ctrl_regs (
		.clk          (clk),
		.reset        (reset),
		.bus          (bus.unit),
		.vblank_enter (vblank_enter),
		.vblank_exit  (vblank_exit),
		.rd_buffer    (rd_buffer),
		.is_pal       (is_pal),
		.pal_color    (pal_color),
		.addr_step    (addr_step),
		.addr_toggle  (addr_toggle),
		.nmi          (nmi),
		.dout         (dout)
	);

	vram_addr_unit u_vram_addr (
		.clk         (clk),
		.reset       (reset),
		.bus         (bus.unit),
		.addr_toggle (addr_toggle),
		.addr_step   (addr_step),
		.vram_din    (vram_din),
		.vram_a      (vram_a),
		.vram_r      (vram_r),
		.vram_w      (vram_w),
		.is_pal      (is_pal),
		.pal_addr    (pal_addr),
		.rd_buffer   (rd_buffer)
	);

	palette_ram u_palette (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus.unit),
		.pal_addr  (pal_addr),
		.is_pal    (is_pal),
		.pal_color (pal_color)
	);

endmodule

`default_nettype wire

// ==== tb/ppu_props.sv ====
/*
 * PPU strobe and NMI properties
 * Bound into the control registers and the VRAM address unit
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_props #(
	parameter bit CHECK_STROBES = 1'b1, // Bound block drives the VRAM strobes
	parameter bit CHECK_NMI     = 1'b1  // Bound block drives nmi
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic write,
	input wire logic vram_r,
	input wire logic vram_w,
	input wire logic nmi
);
	int unsigned fail_count = 0;

	if (CHECK_STROBES) begin : g_strobes
		// External VRAM sees one direction per cycle
		a_strobe_excl: assert property (@(posedge clk) disable iff (reset) !(vram_r && vram_w))
			else begin
				$error("vram_r and vram_w high in the same cycle");
				fail_count++;
			end

		// A VRAM write only ever comes from a CPU write
		a_write_src: assert property (@(posedge clk) disable iff (reset) vram_w |-> write)
			else begin
				$error("vram_w high without a CPU write");
				fail_count++;
			end
	end

	if (CHECK_NMI) begin : g_nmi
		// Second reset cycle on, nmi held low
		a_nmi_reset: assert property (@(posedge clk) reset ##1 reset |-> !nmi)
			else begin
				$error("nmi high while reset is asserted");
				fail_count++;
			end
	end

endmodule

bind ppu_ctrl_regs ppu_props #(
	.CHECK_STROBES (1'b0)
) ctrl_props (
	.clk    (clk),
	.reset  (reset),
	.write  (bus.wr),
	.vram_r (1'b0),  // No strobes at this level
	.vram_w (1'b0),
	.nmi    (nmi)
);

bind vram_addr_unit ppu_props #(
	.CHECK_NMI (1'b0)
) vram_props (
	.clk    (clk),
	.reset  (reset),
	.write  (bus.wr),
	.vram_r (vram_r),
	.vram_w (vram_w),
	.nmi    (1'b0)   // NMI lives in the control block
);

`default_nettype wire

// ==== tb/ppu_tb.sv ====
/*
 * PPU register core testbench
 * Plays the access trace against ppu_top, with a VRAM model on the far side
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_tb;
	import ppu_pkg::*;

	localparam int    CYCLES_PER_LINE = 341;
	localparam int    VBLANK_LINE     = 241;
	localparam int    LAST_LINE       = 260;
	localparam int    FRAME_CYCLES    = CYCLES_PER_LINE * (LAST_LINE + 2); // With pre-render line
	localparam string TRACE_FILE      = "tb/ppu_trace.txt";

	logic       clk;
	logic       reset;
	logic [2:0] ain;
	cpu_byte_t  din;
	logic       read;
	logic       write;
	cpu_byte_t  vram_din;
	cpu_byte_t  dout;
	logic       nmi;
	logic       vram_r;
	logic       vram_w;
	vram_addr_t vram_a;
	cpu_byte_t  vram_dout;
	logic [8:0] scanline;
	logic [8:0] cycle;

	// Trace commands, parallel queues
	string       cmd_q[$];
	string       name_q[$];
	logic [15:0] arg_a_q[$];
	logic [15:0] arg_b_q[$];
	bit          loaded;

	string       cur_test;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	logic        exp_wr_pending; // Next data write must reach VRAM
	vram_addr_t  exp_wr_addr;
	logic        vram_req;       // Read seen in the previous cycle
	vram_addr_t  vram_req_addr;

	ppu_top dut (
		.clk       (clk),
		.reset     (reset),
		.ain       (ain),
		.din       (din),
		.read      (read),
		.write     (write),
		.vram_din  (vram_din),
		.dout      (dout),
		.nmi       (nmi),
		.vram_r    (vram_r),
		.vram_w    (vram_w),
		.vram_a    (vram_a),
		.vram_dout (vram_dout),
		.scanline  (scanline),
		.cycle     (cycle)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// VRAM content: low address byte XOR high byte
	function automatic cpu_byte_t vram_model(input vram_addr_t a);
		return a[7:0] ^ {2'b00, a[13:8]};
	endfunction

	// Strobe sampled mid-cycle, data answered just after the next edge
	always @(negedge clk) begin
		vram_req      = vram_r;
		vram_req_addr = vram_a;
		if (vram_r && vram_a[13:8] == PAL_PAGE) begin // Palette reads stay inside the core
			$display("Error in %s: VRAM read strobe raised at palette address %h",
				cur_test, vram_a);
			note_error();
		end
	end

	always @(posedge clk) begin
		#2;
		if (vram_req)
			vram_din = vram_model(vram_req_addr);
	end

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_byte(input string what, input cpu_byte_t exp, input cpu_byte_t act);
		if (exp !== act) begin
			$display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic check_addr(input string what, input vram_addr_t exp, input vram_addr_t act);
		if (exp !== act) begin
			$display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Mismatch in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic check_count(input string what, input logic [8:0] exp, input logic [8:0] act);
		if (exp !== act) begin
			$display("Mismatch in %s, %s: expected %0d, actual %0d", cur_test, what, exp, act);
			note_error();
		end
	endtask

	// Called at edge+2; strobe cycle, then one idle cycle
	task automatic do_write(input logic [2:0] a, input cpu_byte_t d);
		ain   = a;
		din   = d;
		write = 1'b1;
		#8; // Mid-cycle, combinational strobes settled
		if (a == 3'd7) begin
			check_flag("vram_w", exp_wr_pending, vram_w);
			if (exp_wr_pending) begin
				check_addr("vram_a", exp_wr_addr, vram_a);
				check_byte("vram_dout", d, vram_dout);
			end
		end
		exp_wr_pending = 1'b0;
		@(posedge clk);
		#2;
		write = 1'b0;
		check_byte("dout after write", d, dout); // Latch takes every write
		@(posedge clk);
		#2;
	endtask

	task automatic do_read(input logic [2:0] a, input cpu_byte_t exp);
		ain  = a;
		read = 1'b1;
		@(posedge clk);
		#2;
		read = 1'b0;
		check_byte($sformatf("dout of reg %0d", a), exp, dout);
		@(posedge clk);
		#2;
	endtask

	// Runs until nmi rises, then checks the cycle before it
	task automatic wait_vblank();
		int         n;
		logic [8:0] prev_line;
		logic [8:0] prev_cycle;
		n          = 0;
		prev_line  = scanline;
		prev_cycle = cycle;
		while (!nmi && n < FRAME_CYCLES + 16) begin
			prev_line  = scanline;
			prev_cycle = cycle;
			@(posedge clk);
			#2;
			n++;
		end
		if (!nmi) begin
			$display("Error in %s: nmi did not rise within one frame", cur_test);
			note_error();
		end else begin
			check_count("scanline at vblank entry", 9'(VBLANK_LINE), prev_line);
			check_count("cycle at vblank entry", 9'd0, prev_cycle);
		end
	endtask

	task automatic finish_test();
		if (cur_test != "") begin
			tests_run++;
			if (test_errors == 0) begin
				$display("%s: ok", cur_test);
			end else begin
				tests_failed++;
				$display("%s: FAILED, %0d bad checks", cur_test, test_errors);
			end
		end
		test_errors = 0;
	endtask

	task automatic load_trace();
		int                 fd;
		int                 r;
		int                 want;
		bit                 keep;
		string              tok;
		string              name;
		logic [15:0]        a;
		logic [15:0]        b;
		logic [8*128-1:0]   rest;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Error: cannot open trace file %s", TRACE_FILE);
			errors++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				keep = 1'b1;
				name = "";
				a    = '0;
				b    = '0;
				r    = 0;
				want = 0; // Argument count of the command
				if (tok == "#") begin
					r    = $fgets(rest, fd); // Comment runs to end of line
					keep = 1'b0;
				end else if (tok == "T") begin
					want = 1;
					r    = $fscanf(fd, "%s", name);
				end else if (tok == "W" || tok == "R") begin
					want = 2;
					r    = $fscanf(fd, "%h %h", a, b);
				end else if (tok == "A" || tok == "N") begin
					want = 1;
					r    = $fscanf(fd, "%h", a);
				end else if (tok != "V") begin
					$display("Error: unknown trace command %s", tok);
					errors++;
					keep = 1'b0;
				end
				if (keep && r != want) begin
					$display("Error: trace command %s has missing arguments", tok);
					errors++;
					keep = 1'b0;
				end
				if (keep) begin
					cmd_q.push_back(tok);
					name_q.push_back(name);
					arg_a_q.push_back(a);
					arg_b_q.push_back(b);
				end
			end
			$fclose(fd);
		end
	endtask

	// Whole trace plus two frames of slack
	initial begin
		int limit;
		wait (loaded);
		limit = 8 + 4 * cmd_q.size() + 2 * FRAME_CYCLES;
		repeat (limit) @(posedge clk);
		$display("Timeout: trace still running after %0d cycles", limit);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int prop_fails;
		reset          = 1'b1;
		ain            = 3'd0;
		din            = '0;
		read           = 1'b0;
		write          = 1'b0;
		vram_din       = '0;
		vram_req       = 1'b0;
		vram_req_addr  = '0;
		exp_wr_pending = 1'b0;
		exp_wr_addr    = '0;
		cur_test       = "";
		errors         = 0;
		test_errors    = 0;
		tests_run      = 0;
		tests_failed   = 0;
		loaded         = 1'b0;
		load_trace();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		@(posedge clk);
		#2;
		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"T": begin
					finish_test();
					cur_test = name_q[i];
				end
				"W": do_write(arg_a_q[i][2:0], arg_b_q[i][7:0]);
				"R": do_read(arg_a_q[i][2:0], arg_b_q[i][7:0]);
				"A": begin
					exp_wr_pending = 1'b1;
					exp_wr_addr    = arg_a_q[i][13:0];
				end
				"N": check_flag("nmi", arg_a_q[i][0], nmi);
				"V": wait_vblank();
				default: ;
			endcase
		end
		finish_test();
		prop_fails = dut.u_ctrl_regs.ctrl_props.fail_count
			+ dut.u_vram_addr.vram_props.fail_count;
		$display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, prop_fails);
		if (errors == 0 && tests_failed == 0 && prop_fails == 0 && tests_run > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/ppu_trace.txt ====
# Columns: command, then hex args. T name | W ain data | R ain expected_dout
# A expected vram_a of next data write | N expected nmi | V wait for vblank entry
T addr_writes
W 0 00
W 6 21
W 6 08
A 2108
W 7 a5
A 2109
W 7 5a
W 0 04
A 210a
W 7 11
A 212a
W 7 22
T buffered_reads
W 0 00
W 6 23
W 6 c0
R 7 00
R 7 e3
R 7 e2
W 0 04
R 7 e1
R 7 e0
R 7 c0
W 6 01
W 6 55
R 7 27
R 7 54
T palette
W 0 00
W 6 3f
W 6 00
W 7 2c
W 7 15
W 6 3f
W 6 10
W 1 c0
R 7 ec
R 7 c0
W 6 3f
W 6 01
R 7 15
T toggle_reset
W 6 2a
R 2 0a
W 6 12
W 6 34
A 1234
W 7 99
W 5 00
R 2 00
W 6 05
W 6 67
A 0567
W 7 42
T open_bus
W 1 9d
R 3 9d
R 4 9d
R 2 1d
T vblank_nmi
W 0 80
N 0
V
N 1
R 2 80
N 0
R 2 00
N 0

// ==== project.f ====
hdl/ppu_pkg.sv
hdl/ppu_bus_if.sv
hdl/frame_timer.sv
hdl/ppu_ctrl_regs.sv
hdl/vram_addr_unit.sv
hdl/palette_ram.sv
hdl/ppu_top.sv
tb/ppu_props.sv
tb/ppu_tb.sv
